//--- compile.f
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_types_pkg.sv
hdl/ctrl.sv
hdl/pc_reg.sv
hdl/pipe_reg.sv
hdl/id_stage.sv
hdl/core_frontend.sv
dv/tb_core_frontend.sv

//--- Bender.yml
package:
  name: core_frontend

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_types_pkg.sv
      - hdl/ctrl.sv
      - hdl/pc_reg.sv
      - hdl/pipe_reg.sv
      - hdl/id_stage.sv
      - hdl/core_frontend.sv
      - target: simulation
        files:
          - dv/tb_core_frontend.sv

//--- dv/tb_core_frontend.sv
// front end directed testbench
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module tb_core_frontend;

    logic                        clk;
    logic                        reset_i;
    logic [`INST_ADDR_WIDTH-1:0] inst_addr_o;
    logic [`INST_DATA_WIDTH-1:0] inst_i;
    logic                        jump_flag_i;
    logic [`INST_ADDR_WIDTH-1:0] jump_addr_i;
    logic                        hold_flag_ex_i;
    logic                        hold_flag_rib_i;
    logic                        hold_flag_clint_i;
    logic                        ex_valid_o;
    logic [31:0]                 ex_pc_o;
    logic [31:0]                 ex_inst_o;
    rv_isa_pkg::opcode_t         ex_opcode_o;
    logic [4:0]                  ex_rd_o;
    logic [4:0]                  ex_rs1_o;
    logic [4:0]                  ex_rs2_o;
    logic [31:0]                 ex_imm_o;
    rv_isa_pkg::fmt_t            ex_fmt_o;

    // instruction rom, word index from address bits [7:2]
    logic [31:0] rom [0:63];
    // expected pipeline state
    logic [31:0] m_pc;
    logic        m_ifid_v;
    logic [31:0] m_ifid_pc;
    logic        m_idex_v;
    logic [31:0] m_idex_pc;
    integer      errors;
    integer      seed;
    string       test_name;

    core_frontend u_core_frontend (
        .clk              (clk),
        .reset_i          (reset_i),
        .inst_addr_o      (inst_addr_o),
        .inst_i           (inst_i),
        .jump_flag_i      (jump_flag_i),
        .jump_addr_i      (jump_addr_i),
        .hold_flag_ex_i   (hold_flag_ex_i),
        .hold_flag_rib_i  (hold_flag_rib_i),
        .hold_flag_clint_i(hold_flag_clint_i),
        .ex_valid_o       (ex_valid_o),
        .ex_pc_o          (ex_pc_o),
        .ex_inst_o        (ex_inst_o),
        .ex_opcode_o      (ex_opcode_o),
        .ex_rd_o          (ex_rd_o),
        .ex_rs1_o         (ex_rs1_o),
        .ex_rs2_o         (ex_rs2_o),
        .ex_imm_o         (ex_imm_o),
        .ex_fmt_o         (ex_fmt_o)
    );

    // same-cycle instruction port
    assign inst_i = rom[inst_addr_o[7:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // opcode to format, per the rv32i base encodings
    function automatic logic [2:0] ref_fmt(input logic [6:0] op);
        case (op)
            rv_isa_pkg::lui, rv_isa_pkg::auipc: ref_fmt = rv_isa_pkg::fmt_u;
            rv_isa_pkg::jal:                    ref_fmt = rv_isa_pkg::fmt_j;
            rv_isa_pkg::branch:                 ref_fmt = rv_isa_pkg::fmt_b;
            rv_isa_pkg::store:                  ref_fmt = rv_isa_pkg::fmt_s;
            rv_isa_pkg::op:                     ref_fmt = rv_isa_pkg::fmt_r;
            rv_isa_pkg::jalr, rv_isa_pkg::load,
            rv_isa_pkg::op_imm, rv_isa_pkg::system: ref_fmt = rv_isa_pkg::fmt_i;
            default:                            ref_fmt = rv_isa_pkg::fmt_bad;
        endcase
    endfunction

    // sign-extended immediate, zero for r and unknown
    function automatic logic [31:0] ref_imm(input logic [31:0] w);
        logic [31:0] sx;
        sx = {32{w[31]}};
        case (ref_fmt(w[6:0]))
            rv_isa_pkg::fmt_i: ref_imm = {sx[31:12], w[31:20]};
            rv_isa_pkg::fmt_s: ref_imm = {sx[31:12], w[31:25], w[11:7]};
            rv_isa_pkg::fmt_b: ref_imm = {sx[31:12], w[7], w[30:25], w[11:8], 1'b0};
            rv_isa_pkg::fmt_u: ref_imm = {w[31:12], 12'h000};
            rv_isa_pkg::fmt_j: ref_imm = {sx[31:20], w[19:12], w[20], w[30:21], 1'b0};
            default:           ref_imm = 32'h0;
        endcase
    endfunction

    task automatic compare(input string field, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors++;
            $display("mismatch %s %s: expected %h actual %h", test_name, field, exp, act);
        end
    endtask

    // fetch address and ex outputs against expected state
    task automatic check_outputs;
        logic [31:0] w;
        compare("inst_addr", m_pc, inst_addr_o);
        compare("ex_valid", {31'h0, m_idex_v}, {31'h0, ex_valid_o});
        if (m_idex_v) begin
            w = rom[m_idex_pc[7:2]];
            compare("ex_pc", m_idex_pc, ex_pc_o);
            compare("ex_inst", w, ex_inst_o);
            compare("ex_opcode", {25'h0, w[6:0]}, {25'h0, ex_opcode_o});
            compare("ex_rd", {27'h0, w[11:7]}, {27'h0, ex_rd_o});
            compare("ex_rs1", {27'h0, w[19:15]}, {27'h0, ex_rs1_o});
            compare("ex_rs2", {27'h0, w[24:20]}, {27'h0, ex_rs2_o});
            compare("ex_imm", ref_imm(w), ex_imm_o);
            compare("ex_fmt", {29'h0, ref_fmt(w[6:0])}, {29'h0, ex_fmt_o});
        end
    endtask

    // one clock with these requests, expected state stepped at the edge
    task automatic run_cycle(input logic jf, input logic [31:0] ja, input logic ex,
                             input logic rib, input logic clint);
        logic [1:0] lvl;
        jump_flag_i       = jf;
        jump_addr_i       = ja;
        hold_flag_ex_i    = ex;
        hold_flag_rib_i   = rib;
        hold_flag_clint_i = clint;
        // jump, ex or clint above bus hold
        if (jf || ex || clint) begin
            lvl = 2'd2;
        end else if (rib) begin
            lvl = 2'd1;
        end else begin
            lvl = 2'd0;
        end
        @(posedge clk);
        // id/ex only bubbles at the top level
        m_idex_v  = (lvl == 2'd2) ? 1'b0 : m_ifid_v;
        m_idex_pc = m_ifid_pc;
        m_ifid_v  = (lvl == 2'd0);
        m_ifid_pc = m_pc;
        if (jf) begin
            m_pc = ja;
        end else if (lvl == 2'd0) begin
            m_pc = m_pc + 32'd4;
        end
        #1;
        check_outputs();
    endtask

    task automatic run_idle(input integer n);
        repeat (n) run_cycle(1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
    endtask

    // idle until ex_valid_o, bounded
    task automatic wait_ex_valid;
        logic   found;
        integer n;
        found = 1'b0;
        for (n = 0; n < 50 && !found; n++) begin
            run_cycle(1'b0, 32'h0, 1'b0, 1'b0, 1'b0);
            found = ex_valid_o;
        end
        if (!found) begin
            errors++;
            $display("%s: no valid instruction reached execute within 50 cycles", test_name);
        end
    endtask

    task automatic load_rom;
        integer i;
        // filler from the full word index, mostly unknown opcodes
        for (i = 0; i < 64; i++) begin
            rom[i] = (i * 32'h9e37_79b1) + 32'h1357_2468;
        end
        rom[0]  = 32'h1234_50b7;  // lui x1, 0x12345
        rom[1]  = 32'hffff_f117;  // auipc x2, 0xfffff
        rom[2]  = 32'hff9f_f0ef;  // jal x1, -8
        rom[3]  = 32'h0000_8067;  // jalr x0, 0(x1)
        rom[4]  = 32'hfe20_88e3;  // beq x1, x2, -16
        rom[5]  = 32'hffc1_2283;  // lw x5, -4(x2)
        rom[6]  = 32'hfe51_2c23;  // sw x5, -8(x2)
        rom[7]  = 32'hfff1_8193;  // addi x3, x3, -1
        rom[9]  = 32'h0020_8233;  // add x4, x1, x2
        rom[10] = 32'h0000_0073;  // ecall
        rom[11] = 32'hffff_ffff;
        rom[12] = `INST_NOP;
    endtask

    task automatic test_reset;
        test_name = "reset";
        reset_i = 1'b1;
        repeat (3) @(posedge clk);
        #1;
        reset_i   = 1'b0;
        m_pc      = `RESET_PC;
        m_ifid_v  = 1'b0;
        m_ifid_pc = 32'h0;
        m_idex_v  = 1'b0;
        m_idex_pc = 32'h0;
        if (inst_addr_o !== `RESET_PC) begin
            errors++;
            $display("mismatch %s inst_addr: expected %h actual %h",
                     test_name, `RESET_PC, inst_addr_o);
        end
        if (ex_valid_o !== 1'b0) begin
            errors++;
            $display("mismatch %s ex_valid: expected 0 actual %b", test_name, ex_valid_o);
        end
        run_idle(1);
    endtask

    task automatic test_straight;
        integer count;
        test_name = "straight";
        count = 0;
        repeat (20) begin
            run_idle(1);
            count += ex_valid_o;
        end
        // pipe already primed, every cycle valid
        if (count != 20) begin
            errors++;
            $display("mismatch %s valid_count: expected 20 actual %0d", test_name, count);
        end
    endtask

    task automatic test_jump;
        test_name = "jump";
        run_idle(2);
        run_cycle(1'b1, 32'h0000_0020, 1'b0, 1'b0, 1'b0);
        wait_ex_valid();
        // first valid after the redirect is the target
        if (ex_pc_o !== 32'h0000_0020) begin
            errors++;
            $display("mismatch %s ex_pc: expected %h actual %h", test_name, 32'h20, ex_pc_o);
        end
        run_idle(4);
    endtask

    task automatic test_bus_hold;
        logic [31:0] held;
        test_name = "bus_hold";
        held = inst_addr_o;
        repeat (4) begin
            run_cycle(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
            if (inst_addr_o !== held) begin
                errors++;
                $display("mismatch %s inst_addr: expected %h actual %h",
                         test_name, held, inst_addr_o);
            end
        end
        run_idle(6);
    endtask

    task automatic test_ex_clint_hold;
        integer len;
        logic   use_ex;
        test_name = "ex_clint_hold";
        repeat (6) begin
            len    = 1 + ({$random(seed)} % 4);
            use_ex = $random(seed) & 1;
            repeat (len) begin
                run_cycle(1'b0, 32'h0, use_ex, 1'b0, !use_ex);
                if (ex_valid_o !== 1'b0) begin
                    errors++;
                    $display("mismatch %s ex_valid: expected 0 actual %b", test_name, ex_valid_o);
                end
            end
            run_idle(2 + ({$random(seed)} % 3));
        end
        run_idle(4);
    endtask

    task automatic test_priority;
        logic [31:0] held;
        test_name = "priority";
        held = inst_addr_o;
        // bus and ex together act as hold_id
        repeat (3) begin
            run_cycle(1'b0, 32'h0, 1'b1, 1'b1, 1'b0);
            if (inst_addr_o !== held || ex_valid_o !== 1'b0) begin
                errors++;
                $display("mismatch %s pc/valid: expected %h/0 actual %h/%b",
                         test_name, held, inst_addr_o, ex_valid_o);
            end
        end
        // redirect under a bus hold
        run_cycle(1'b1, 32'h0000_0040, 1'b0, 1'b1, 1'b0);
        if (inst_addr_o !== 32'h0000_0040) begin
            errors++;
            $display("mismatch %s inst_addr: expected %h actual %h", test_name, 32'h40, inst_addr_o);
        end
        repeat (2) run_cycle(1'b0, 32'h0, 1'b0, 1'b1, 1'b0);
        run_idle(5);
    endtask

    initial begin
        errors            = 0;
        seed              = 32'h239d_8768;
        test_name         = "init";
        reset_i           = 1'b1;
        jump_flag_i       = 1'b0;
        jump_addr_i       = 32'h0;
        hold_flag_ex_i    = 1'b0;
        hold_flag_rib_i   = 1'b0;
        hold_flag_clint_i = 1'b0;
        load_rom();
        test_reset();
        test_straight();
        test_jump();
        test_bus_hold();
        test_ex_clint_hold();
        test_priority();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/core_frontend.sv
// instruction front end top
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module core_frontend (
    input  wire                         clk,
    input  wire                         reset_i,
    // instruction port, word returned in the same cycle
    output logic [`INST_ADDR_WIDTH-1:0] inst_addr_o,
    input  wire  [`INST_DATA_WIDTH-1:0] inst_i,
    // from execute
    input  wire                         jump_flag_i,
    input  wire  [`INST_ADDR_WIDTH-1:0] jump_addr_i,
    input  wire                         hold_flag_ex_i,
    // from bus and interrupt controller
    input  wire                         hold_flag_rib_i,
    input  wire                         hold_flag_clint_i,
    // decoded instruction towards execute
    output logic                        ex_valid_o,
    output logic [`INST_ADDR_WIDTH-1:0] ex_pc_o,
    output logic [`INST_DATA_WIDTH-1:0] ex_inst_o,
    output rv_isa_pkg::opcode_t         ex_opcode_o,
    output logic [4:0]                  ex_rd_o,
    output logic [4:0]                  ex_rs1_o,
    output logic [4:0]                  ex_rs2_o,
    output logic [31:0]                 ex_imm_o,
    output rv_isa_pkg::fmt_t            ex_fmt_o
);

    // bubble payloads, pc 0 with a nop word
    localparam core_types_pkg::fetch_t IF_BUBBLE = '{
        pc:   '0,
        inst: `INST_NOP
    };
    localparam core_types_pkg::decode_t ID_BUBBLE = '{
        pc:     '0,
        inst:   `INST_NOP,
        opcode: rv_isa_pkg::op_imm,
        rd:     '0,
        rs1:    '0,
        rs2:    '0,
        imm:    '0,
        fmt:    rv_isa_pkg::fmt_i
    };

    core_types_pkg::hold_t       hold;
    logic                        jump_flag;
    logic [`INST_ADDR_WIDTH-1:0] jump_addr;
    logic [`INST_ADDR_WIDTH-1:0] pc;
    core_types_pkg::fetch_t      fetch_data;
    logic                        if_id_valid;
    core_types_pkg::fetch_t      if_id_data;
    logic                        id_valid;
    core_types_pkg::decode_t     id_data;
    core_types_pkg::decode_t     ex_data;

    ctrl u_ctrl (
        .jump_flag_i      (jump_flag_i),
        .jump_addr_i      (jump_addr_i),
        .hold_flag_ex_i   (hold_flag_ex_i),
        .hold_flag_rib_i  (hold_flag_rib_i),
        .hold_flag_clint_i(hold_flag_clint_i),
        .hold_o           (hold),
        .jump_flag_o      (jump_flag),
        .jump_addr_o      (jump_addr)
    );

    pc_reg u_pc_reg (
        .clk        (clk),
        .reset_i    (reset_i),
        .hold_i     (hold),
        .jump_flag_i(jump_flag),
        .jump_addr_i(jump_addr),
        .pc_o       (pc)
    );

    // fetch: address out, word back combinationally
    assign inst_addr_o     = pc;
    assign fetch_data.pc   = pc;
    assign fetch_data.inst = inst_i;

    // if/id bubbles on any hold, a held pc gets refetched
    pipe_reg #(
        .T          (core_types_pkg::fetch_t),
        .FLUSH_LEVEL(core_types_pkg::hold_pc),
        .BUBBLE     (IF_BUBBLE)
    ) u_if_id (
        .clk    (clk),
        .reset_i(reset_i),
        .hold_i (hold),
        .valid_i(1'b1),
        .data_i (fetch_data),
        .valid_o(if_id_valid),
        .data_o (if_id_data)
    );

    id_stage u_id_stage (
        .valid_i (if_id_valid),
        .pc_i    (if_id_data.pc),
        .inst_i  (if_id_data.inst),
        .valid_o (id_valid),
        .pc_o    (id_data.pc),
        .inst_o  (id_data.inst),
        .opcode_o(id_data.opcode),
        .rd_o    (id_data.rd),
        .rs1_o   (id_data.rs1),
        .rs2_o   (id_data.rs2),
        .imm_o   (id_data.imm),
        .fmt_o   (id_data.fmt)
    );

    // id/ex keeps moving under a bus hold, bubbles only at hold_id
    pipe_reg #(
        .T          (core_types_pkg::decode_t),
        .FLUSH_LEVEL(core_types_pkg::hold_id),
        .BUBBLE     (ID_BUBBLE)
    ) u_id_ex (
        .clk    (clk),
        .reset_i(reset_i),
        .hold_i (hold),
        .valid_i(id_valid),
        .data_i (id_data),
        .valid_o(ex_valid_o),
        .data_o (ex_data)
    );

    // execute side fields
    assign ex_pc_o     = ex_data.pc;
    assign ex_inst_o   = ex_data.inst;
    assign ex_opcode_o = ex_data.opcode;
    assign ex_rd_o     = ex_data.rd;
    assign ex_rs1_o    = ex_data.rs1;
    assign ex_rs2_o    = ex_data.rs2;
    assign ex_imm_o    = ex_data.imm;
    assign ex_fmt_o    = ex_data.fmt;

endmodule

`default_nettype wire

//--- hdl/id_stage.sv
// rv32i instruction decoder
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module id_stage (
    // from if/id
    input  wire                         valid_i,
    input  wire [`INST_ADDR_WIDTH-1:0]  pc_i,
    input  wire [`INST_DATA_WIDTH-1:0]  inst_i,
    // to id/ex
    output logic                        valid_o,
    output logic [`INST_ADDR_WIDTH-1:0] pc_o,
    output logic [`INST_DATA_WIDTH-1:0] inst_o,
    output rv_isa_pkg::opcode_t         opcode_o,
    output logic [4:0]                  rd_o,
    output logic [4:0]                  rs1_o,
    output logic [4:0]                  rs2_o,
    output logic [31:0]                 imm_o,
    output rv_isa_pkg::fmt_t            fmt_o
);

    // pass-through of stage context
    assign valid_o = valid_i;
    assign pc_o    = pc_i;
    assign inst_o  = inst_i;

    // register indices sit at fixed positions in every format
    assign rd_o  = inst_i[11:7];
    assign rs1_o = inst_i[19:15];
    assign rs2_o = inst_i[24:20];

    // raw opcode, may hold a value outside the enum
    assign opcode_o = rv_isa_pkg::opcode_t'(inst_i[6:0]);

    // opcode to format
    always_comb begin
        case (opcode_o)
            rv_isa_pkg::lui,
            rv_isa_pkg::auipc:  fmt_o = rv_isa_pkg::fmt_u;
            rv_isa_pkg::jal:    fmt_o = rv_isa_pkg::fmt_j;
            rv_isa_pkg::jalr,
            rv_isa_pkg::load,
            rv_isa_pkg::op_imm,
            rv_isa_pkg::system: fmt_o = rv_isa_pkg::fmt_i;
            rv_isa_pkg::branch: fmt_o = rv_isa_pkg::fmt_b;
            rv_isa_pkg::store:  fmt_o = rv_isa_pkg::fmt_s;
            rv_isa_pkg::op:     fmt_o = rv_isa_pkg::fmt_r;
            default:            fmt_o = rv_isa_pkg::fmt_bad;
        endcase
    end

    // immediate assembly, sign bit is always inst[31]
    always_comb begin
        case (fmt_o)
            rv_isa_pkg::fmt_i:
                imm_o = {{20{inst_i[31]}}, inst_i[31:20]};
            rv_isa_pkg::fmt_s:
                imm_o = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
            // branch offsets are halfword scaled
            rv_isa_pkg::fmt_b:
                imm_o = {{19{inst_i[31]}}, inst_i[31], inst_i[7],
                         inst_i[30:25], inst_i[11:8], 1'b0};
            // upper 20 bits, low 12 cleared
            rv_isa_pkg::fmt_u:
                imm_o = {inst_i[31:12], 12'b0};
            rv_isa_pkg::fmt_j:
                imm_o = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                         inst_i[20], inst_i[30:21], 1'b0};
            // r format and unknown opcodes carry no immediate
            default:
                imm_o = 32'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/pipe_reg.sv
// pipeline stage register
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
    // payload carried by this stage
    parameter type T = logic [31:0],
    // hold level at which this stage bubbles
    parameter core_types_pkg::hold_t FLUSH_LEVEL = core_types_pkg::hold_pc,
    // payload loaded with a bubble
    parameter T BUBBLE = T'('0)
) (
    input  wire                        clk,
    input  wire                        reset_i,
    input  wire core_types_pkg::hold_t hold_i,
    // upstream side
    input  wire                        valid_i,
    input  wire T                      data_i,
    // downstream side
    output logic                       valid_o,
    output T                           data_o
);

    logic flush;

    // bubble when hold reaches this stage
    assign flush = (hold_i >= FLUSH_LEVEL);

    always_ff @(posedge clk) begin
        if (reset_i || flush) begin
            // empty slot, nop payload
            valid_o <= 1'b0;
            data_o  <= BUBBLE;
        end else begin
            valid_o <= valid_i;
            data_o  <= data_i;
        end
    end

    // valid must be clean once out of reset
    // catches an x hold level or an undriven valid upstream
    property p_valid_known;
        @(posedge clk) disable iff (reset_i)
        !reset_i |=> !$isunknown(valid_o);
    endproperty

    a_valid_known : assert property (p_valid_known)
        else $error("pipe_reg: valid_o unknown after reset");

endmodule

`default_nettype wire

//--- hdl/pc_reg.sv
// program counter
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module pc_reg (
    input  wire                         clk,
    input  wire                         reset_i,
    // merged hold level from ctrl
    input  wire core_types_pkg::hold_t  hold_i,
    // single-cycle redirect pulse
    input  wire                         jump_flag_i,
    input  wire [`INST_ADDR_WIDTH-1:0]  jump_addr_i,
    // current fetch address
    output logic [`INST_ADDR_WIDTH-1:0] pc_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_o <= `RESET_PC;
        end else if (jump_flag_i) begin
            // jump wins over any hold
            pc_o <= jump_addr_i;
        end else if (hold_i >= core_types_pkg::hold_pc) begin
            // refetch same address next cycle
            pc_o <= pc_o;
        end else begin
            // sequential fetch
            pc_o <= pc_o + `INST_ADDR_WIDTH'd4;
        end
    end

    // execute raises a redirect for exactly one cycle
    // a held flag would keep reloading the same target
    property p_jump_pulse;
        @(posedge clk) disable iff (reset_i)
        jump_flag_i |=> !jump_flag_i;
    endproperty

    a_jump_pulse : assert property (p_jump_pulse)
        else $error("pc_reg: jump_flag_i high for more than one cycle");

endmodule

`default_nettype wire

//--- hdl/ctrl.sv
// pipeline hold control
`timescale 1ns/1ps
`default_nettype none
`include "core_settings.svh"

module ctrl (
    // from execute
    input  wire                         jump_flag_i,
    input  wire [`INST_ADDR_WIDTH-1:0]  jump_addr_i,
    input  wire                         hold_flag_ex_i,
    // from bus interconnect
    input  wire                         hold_flag_rib_i,
    // from interrupt controller
    input  wire                         hold_flag_clint_i,
    // to pc_reg and stage registers
    output core_types_pkg::hold_t       hold_o,
    output logic                        jump_flag_o,
    output logic [`INST_ADDR_WIDTH-1:0] jump_addr_o
);

    always_comb begin
        // redirect goes straight through to the pc
        jump_flag_o = jump_flag_i;
        jump_addr_o = jump_addr_i;
        // highest priority first
        if (jump_flag_i || hold_flag_ex_i || hold_flag_clint_i) begin
            // whole front end stops, in-flight words dropped
            hold_o = core_types_pkg::hold_id;
        end else if (hold_flag_rib_i) begin
            // bus busy, only fetch address frozen
            hold_o = core_types_pkg::hold_pc;
        end else begin
            hold_o = core_types_pkg::hold_none;
        end
    end

    // execute must only hand over word-aligned targets
    always_comb begin
        if (jump_flag_i) begin
            a_jump_aligned : assert #0 (jump_addr_i[1:0] == 2'b00)
                else $error("ctrl: misaligned jump target %h", jump_addr_i);
        end
    end

endmodule

`default_nettype wire

//--- hdl/core_types_pkg.sv
// pipeline control and payload types
`default_nettype none
`include "core_settings.svh"

package core_types_pkg;

    // ordered hold levels, higher freezes more of the pipe
    // hold_pc stops fetch, hold_id also flushes if/id and id/ex
    typedef enum logic [1:0] {
        hold_none = 2'd0,
        hold_pc   = 2'd1,
        hold_id   = 2'd2
    } hold_t;

    // if/id payload
    typedef struct packed {
        logic [`INST_ADDR_WIDTH-1:0] pc;
        logic [`INST_DATA_WIDTH-1:0] inst;
    } fetch_t;

    // id/ex payload
    typedef struct packed {
        logic [`INST_ADDR_WIDTH-1:0] pc;
        logic [`INST_DATA_WIDTH-1:0] inst;
        rv_isa_pkg::opcode_t         opcode;
        logic [4:0]                  rd;
        logic [4:0]                  rs1;
        logic [4:0]                  rs2;
        logic [31:0]                 imm;
        rv_isa_pkg::fmt_t            fmt;
    } decode_t;

endpackage

`default_nettype wire

//--- hdl/rv_isa_pkg.sv
// rv32i encoding types
`default_nettype none

package rv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        lui    = 7'b011_0111,
        auipc  = 7'b001_0111,
        jal    = 7'b110_1111,
        jalr   = 7'b110_0111,
        branch = 7'b110_0011,
        load   = 7'b000_0011,
        store  = 7'b010_0011,
        op_imm = 7'b001_0011,
        op     = 7'b011_0011,
        system = 7'b111_0011
    } opcode_t;

    // instruction formats
    // fmt_bad flags an opcode outside the set above
    typedef enum logic [2:0] {
        fmt_r   = 3'd0,
        fmt_i   = 3'd1,
        fmt_s   = 3'd2,
        fmt_b   = 3'd3,
        fmt_u   = 3'd4,
        fmt_j   = 3'd5,
        fmt_bad = 3'd6
    } fmt_t;

endpackage

`default_nettype wire

//--- include/core_settings.svh
// front end build settings
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// instruction address bus width
`define INST_ADDR_WIDTH 32

// instruction word width
`define INST_DATA_WIDTH 32

// first fetch address out of reset
`define RESET_PC 32'h0000_0000

// addi x0, x0, 0
// also serves as the bubble word in the stage registers
`define INST_NOP 32'h0000_0013

`endif
